// ==== tests/ibufVectors.mem ====
// Word 0 is the vector count, then per line: inCtrl status inst0 inst1 inst2 inst3 expCtrl expInst0 expInst1
// inCtrl {cause3..0, flush stall commit decodeReady, exc, csr, valid}, expCtrl {cause1 cause0 ready full stall exc csr valid}
0000001C
0000100A 00000010 00000000 00010013 00000000 00020013 00000000 00000000 00000000
05001005 00000010 00030013 00000000 00040013 00000000 00100003 00010013 00020013
0000100F 00000010 00050013 00060013 00070013 00080013 50100003 00030013 00040013
0000500B 00000010 00090013 000A0013 00000000 000B0013 00000000 00000000 00000000
0000500F 00000010 000C0013 000D0013 000E0013 000F0013 00000000 00000000 00000000
0000500F 00000010 00100013 00110013 00120013 00130013 00000000 00000000 00000000
0000500F 00000010 00E10013 00E20013 00E30013 00E40013 00010000 00000000 00000000
0000100F 00000010 00E10013 00E20013 00E30013 00E40013 00110003 00050013 00060013
0000100F 00000010 00E10013 00E20013 00E30013 00E40013 00110003 00070013 00080013
00000000 00000010 00000000 00000000 00000000 00000000 00100003 00090013 000A0013
00000000 00000010 00000000 00000000 00000000 00000000 00100003 000B0013 000C0013
00000000 00000010 00000000 00000000 00000000 00000000 00100003 000D0013 000E0013
00000000 00000010 00000000 00000000 00000000 00000000 00100003 000F0013 00100013
00000000 00000010 00000000 00000000 00000000 00000000 00100003 00110013 00120013
0000102F 00000010 00140013 00C01073 00150013 00160013 00000000 00000000 00000000
00000000 00000010 00000000 00000000 00000000 00000000 00100003 00130013 00140013
00000000 00000010 00000000 00000000 00000000 00000000 00100011 00C01073 00000000
00000000 00000010 00000000 00000000 00000000 00000000 00001000 00000000 00000000
00002000 00000010 00000000 00000000 00000000 00000000 00001000 00000000 00000000
00000000 00000010 00000000 00000000 00000000 00000000 00100003 00150013 00160013
0000100F 00000010 00A00053 00170013 00B00053 00180013 00000000 00000000 00000000
00000000 00000010 00000000 00000000 00000000 00000000 00100003 00A00053 00170013
00001003 00000000 00190013 001A0013 00000000 00000000 07100101 00B00053 00000000
00002000 00000010 00000000 00000000 00000000 00000000 00001000 00000000 00000000
00009001 00000010 00E50013 00000000 00000000 00000000 00001000 00000000 00000000
00001001 00000010 001B0013 00000000 00000000 00000000 00000000 00000000 00000000
00001001 00000010 001C0013 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000010 00000000 00000000 00000000 00000000 00100003 001B0013 001C0013

// ==== tests/instructionBufferTb.sv ====
/* Instruction buffer testbench
   Replays per-cycle vectors from a hex file and checks the dispatch bundle */
`timescale 1ns/100ps
`default_nettype none

module instructionBufferTb
  import ibufPkg::*;
();

  localparam int CLK_PERIOD = 8;
  localparam int RESET_CYCLES = 8;
  // Words per vector line and room for the whole file
  localparam int VEC_WORDS = 9;
  localparam int MAX_VECS = 64;
  localparam int RESET_TIMEOUT = 20;

  logic clk;
  logic reset;
  logic flush;
  logic stall;
  logic commitCsr;
  logic decodeReady;
  logic [STATUS_BITS-1:0] statusWord;
  logic [WR_LANES-1:0] inValid;
  logic [WR_LANES-1:0][INST_BITS-1:0] inInst;
  logic [WR_LANES-1:0] inIsCsr;
  logic [WR_LANES-1:0] inException;
  logic [WR_LANES-1:0][CAUSE_BITS-1:0] inCause;
  logic full;
  logic ready;
  logic serializeStall;
  logic [RD_LANES-1:0] outValid;
  logic [RD_LANES-1:0][INST_BITS-1:0] outInst;
  logic [RD_LANES-1:0] outIsCsr;
  logic [RD_LANES-1:0] outException;
  logic [RD_LANES-1:0][CAUSE_BITS-1:0] outCause;

  // Word 0 holds the vector count, lines follow
  logic [31:0] vecMem [VEC_WORDS*MAX_VECS+1];
  int vecCount;
  int vecIdx;

  instructionBuffer uut (
    .clk              (clk),
    .reset            (reset),
    .flush_i          (flush),
    .stall_i          (stall),
    .commitCsr_i      (commitCsr),
    .statusWord_i     (statusWord),
    .decodeReady_i    (decodeReady),
    .inValid_i        (inValid),
    .inInst_i         (inInst),
    .inIsCsr_i        (inIsCsr),
    .inException_i    (inException),
    .inCause_i        (inCause),
    .full_o           (full),
    .ready_o          (ready),
    .serializeStall_o (serializeStall),
    .outValid_o       (outValid),
    .outInst_o        (outInst),
    .outIsCsr_o       (outIsCsr),
    .outException_o   (outException),
    .outCause_o       (outCause)
  );

  initial clk = 1'b0;

  always #(CLK_PERIOD/2) clk = ~clk;

  task automatic abortRun(input string why);
    $display("%s", why);
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    assert (actual === expected)
    else
      abortRun($sformatf("FAIL %s expected %h actual %h", name, expected, actual));
  endtask

  // Quiet decode and dispatch side, FPU enabled
  task automatic driveIdle();
    flush = 1'b0;
    stall = 1'b0;
    commitCsr = 1'b0;
    decodeReady = 1'b0;
    statusWord = STATUS_BITS'(1) << STATUS_FP_EN_BIT;
    inValid = '0;
    inInst = '0;
    inIsCsr = '0;
    inException = '0;
    inCause = '0;
  endtask

  // Control word {cause3..0, flush stall commit decodeReady, exc, csr, valid}
  task automatic applyInputs(input int base);
    logic [31:0] ctrl;
    ctrl = vecMem[base];
    inCause = ctrl[31:16];
    flush = ctrl[15];
    stall = ctrl[14];
    commitCsr = ctrl[13];
    decodeReady = ctrl[12];
    inException = ctrl[11:8];
    inIsCsr = ctrl[7:4];
    inValid = ctrl[3:0];
    statusWord = vecMem[base+1];
    for (int w = 0; w < WR_LANES; w++)
    begin
      inInst[w] = vecMem[base+2+w];
    end
  endtask

  // Expected word {cause1, cause0, ready, full, stall, exc, csr, valid}, a nibble each
  task automatic checkOutputs(input int base);
    logic [31:0] expCtrl;
    expCtrl = vecMem[base+6];
    checkValue("ready_o", expCtrl[20], ready);
    checkValue("full_o", expCtrl[16], full);
    checkValue("serializeStall_o", expCtrl[12], serializeStall);
    checkValue("outValid_o", expCtrl[1:0], outValid);
    checkValue("outIsCsr_o", expCtrl[5:4], outIsCsr);
    checkValue("outException_o", expCtrl[9:8], outException);
    // Payload only matters on lanes that go out
    for (int r = 0; r < RD_LANES; r++)
    begin
      if (expCtrl[r])
      begin
        checkValue($sformatf("outInst_o[%0d]", r), vecMem[base+7+r], outInst[r]);
        checkValue($sformatf("outCause_o[%0d]", r), expCtrl[24+4*r +: 4], outCause[r]);
      end
    end
  endtask

  initial
  begin : stimulus
    int waitCycles;
    reset = 1'b1;
    driveIdle();
    $readmemh("tests/ibufVectors.mem", vecMem);
    vecCount = vecMem[0];
    assert (vecCount > 0)
    else
      abortRun("Vector file is missing or gives a bad vector count");

    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    reset = 1'b0;

    // Outputs must settle to an idle queue
    waitCycles = 0;
    while ((ready !== 1'b0 || full !== 1'b0 || serializeStall !== 1'b0) &&
           waitCycles < RESET_TIMEOUT)
    begin
      @(posedge clk);
      waitCycles++;
    end
    assert (waitCycles < RESET_TIMEOUT)
    else
      abortRun("Timed out waiting for the buffer to leave reset idle");

    // Drive after the edge, sample just before the next one
    vecIdx = 0;
    while (vecIdx < vecCount && vecIdx < MAX_VECS)
    begin
      @(posedge clk);
      #1;
      applyInputs(1 + vecIdx*VEC_WORDS);
      #(CLK_PERIOD-2);
      checkOutputs(1 + vecIdx*VEC_WORDS);
      vecIdx++;
    end
    assert (vecIdx == vecCount)
    else
      abortRun("Timed out before the end of the vectors");

    @(posedge clk);
    #1;
    driveIdle();
    repeat (2) @(posedge clk);
    if (uut.ibufCheck.violations == 0)
    begin
      $display("*** PASSED ***");
      $finish;
    end
    else
    begin
      abortRun("Bound protocol checker reported a violation");
    end
  end

endmodule

`default_nettype wire

// ==== tests/instructionBuffer_checker.sv ====
/* Instruction buffer protocol checker
   Concurrent checks on the dispatch outputs, bound into the top level */
`timescale 1ns/100ps
`default_nettype none

module instructionBufferChecker
  import ibufPkg::*;
(
  input  wire logic                clk,
  input  wire logic                reset,
  input  wire logic                flush_i,
  input  wire logic                ready_o,
  input  wire logic                full_o,
  input  wire logic                serializeStall_o,
  input  wire logic [RD_LANES-1:0] outValid_o
);

  // Failed checks so far
  int violations = 0;

  // Valid lanes form a run starting at lane 0
  contiguousLanes: assert property (@(posedge clk) disable iff (reset)
    ((outValid_o + 1'b1) & outValid_o) == '0)
  else
  begin
    $error("Dispatch lanes are not contiguous from lane 0");
    violations++;
  end

  // Nothing leaves while a CSR or exception holds the bundle
  noValidWhileStalled: assert property (@(posedge clk) disable iff (reset)
    serializeStall_o |-> outValid_o == '0)
  else
  begin
    $error("Dispatch lane valid during a serialization stall");
    violations++;
  end

  // Empty queue right after reset release
  idleAfterReset: assert property (@(posedge clk)
    $fell(reset) |-> !full_o && !ready_o)
  else
  begin
    $error("Full or ready high in the first cycle after reset");
    violations++;
  end

  // Flush leaves nothing to dispatch in the next cycle
  readyLowAfterFlush: assert property (@(posedge clk) disable iff (reset)
    flush_i |=> !ready_o)
  else
  begin
    $error("Ready high in the cycle after a flush");
    violations++;
  end

endmodule

bind instructionBuffer instructionBufferChecker ibufCheck (
  .clk              (clk),
  .reset            (reset),
  .flush_i          (flush_i),
  .ready_o          (ready_o),
  .full_o           (full_o),
  .serializeStall_o (serializeStall_o),
  .outValid_o       (outValid_o)
);

`default_nettype wire

// ==== verilog/ibufDispatchCtrl.sv ====
/* Instruction buffer dispatch control
   FP-disabled marking, bundle masking after CSR or exception, serialization stalls */
`timescale 1ns/100ps
`default_nettype none

module ibufDispatchCtrl
  import ibufPkg::*;
(
  input  wire logic                                     clk,
  input  wire logic                                     reset,
  input  wire logic                                     flush_i,

  // Dispatch side control
  input  wire logic                                     stall_i,
  input  wire logic                                     commitCsr_i,
  input  wire logic [STATUS_BITS-1:0]                   statusWord_i,

  // Occupancy from queue control
  input  wire logic [IBUF_CNT_BITS-1:0]                 entryCount_i,

  // Entries read at head, head+1
  input  wire logic [RD_LANES-1:0][INST_BITS-1:0]       rdInst_i,
  input  wire logic [RD_LANES-1:0]                      rdValid_i,
  input  wire logic [RD_LANES-1:0]                      rdIsCsr_i,
  input  wire logic [RD_LANES-1:0]                      rdException_i,
  input  wire logic [RD_LANES-1:0][CAUSE_BITS-1:0]      rdCause_i,

  // Dispatch bundle
  output logic                                          ready_o,
  output logic                                          serializeStall_o,
  output logic      [RD_LANES-1:0]                      outValid_o,
  output logic      [RD_LANES-1:0]                      outIsCsr_o,
  output logic      [RD_LANES-1:0]                      outException_o,
  output logic      [RD_LANES-1:0][INST_BITS-1:0]       outInst_o,
  output logic      [RD_LANES-1:0][CAUSE_BITS-1:0]      outCause_o,

  // Lanes consumed this cycle
  output logic      [RD_CNT_BITS-1:0]                   popCount_o
);

  logic                  fpOff;
  logic [RD_LANES-1:0]   fpTrap;
  logic [RD_LANES-1:0]   laneExc;
  logic [RD_LANES-1:0]   present;
  logic [RD_LANES-1:0]   laneMask;
  logic [RD_LANES-1:0]   laneGo;

  // Serialization state
  logic                  csrPendQ;
  logic                  excPendQ;
  logic                  csrSent;
  logic                  excSent;

  assign fpOff = ~statusWord_i[STATUS_FP_EN_BIT];

  // FP opcodes trap while the FPU is disabled in the status word
  always_comb
  begin : fpMark
    logic [OPCODE_BITS-1:0] opcode;
    for (int r = 0; r < RD_LANES; r++)
    begin
      opcode = rdInst_i[r][OPCODE_BITS-1:0];
      fpTrap[r] = fpOff &
                  ((opcode == OP_LOAD_FP) || (opcode == OP_STORE_FP) || (opcode == OP_OP_FP));
      laneExc[r] = rdException_i[r] | fpTrap[r];
      outCause_o[r] = fpTrap[r] ? CAUSE_FP_DISABLED : rdCause_i[r];
    end
  end

  // Instruction word passes unchanged
  assign outInst_o = rdInst_i;

  // Lane holds a real entry
  always_comb
  begin
    for (int r = 0; r < RD_LANES; r++)
    begin
      present[r] = rdValid_i[r] & (entryCount_i > IBUF_CNT_BITS'(r));
    end
  end

  // Full bundle waiting, no back-pressure, nothing to serialize behind
  assign ready_o = (entryCount_i >= IBUF_CNT_BITS'(RD_LANES)) & ~stall_i & ~serializeStall_o;

  // Cut the bundle after the first CSR or excepting lane
  always_comb
  begin
    laneMask[0] = 1'b1;
    for (int r = 1; r < RD_LANES; r++)
    begin
      laneMask[r] = laneMask[r-1] & present[r-1] & ~(rdIsCsr_i[r-1] | laneExc[r-1]);
    end
  end

  assign laneGo = {RD_LANES{ready_o}} & laneMask & present;

  assign outValid_o = laneGo;
  assign outIsCsr_o = laneGo & rdIsCsr_i;
  assign outException_o = laneGo & laneExc;

  // Head advances by the lanes actually sent
  always_comb
  begin
    popCount_o = '0;
    for (int r = 0; r < RD_LANES; r++)
    begin
      popCount_o = popCount_o + RD_CNT_BITS'(outValid_o[r]);
    end
  end

  assign csrSent = |outIsCsr_o;
  assign excSent = |outException_o;

  // CSR hold, released by commit or flush
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      csrPendQ <= 1'b0;
    end
    else if (flush_i | commitCsr_i)
    begin
      csrPendQ <= 1'b0;
    end
    else if (csrSent)
    begin
      csrPendQ <= 1'b1;
    end
  end

  // Exception hold, only a flush releases it
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      excPendQ <= 1'b0;
    end
    else if (flush_i)
    begin
      excPendQ <= 1'b0;
    end
    else if (excSent)
    begin
      excPendQ <= 1'b1;
    end
  end

  assign serializeStall_o = csrPendQ | excPendQ;

endmodule

`default_nettype wire

// ==== verilog/ibufPkg.sv ====
/* Instruction buffer shared constants
   Lane counts, queue depth, field widths, FP opcodes and the FP-disabled cause */
`default_nettype none

package ibufPkg;

  // Lane widths of the write and dispatch sides
  localparam int WR_LANES = 4;
  localparam int RD_LANES = 2;

  // Queue geometry
  localparam int IBUF_DEPTH = 16;
  localparam int IBUF_PTR_BITS = 4;
  // One extra bit so a completely full queue can be counted
  localparam int IBUF_CNT_BITS = 5;
  // Dispatched lanes per cycle, 0 to RD_LANES
  localparam int RD_CNT_BITS = 2;

  // Payload fields
  localparam int INST_BITS = 32;
  localparam int CAUSE_BITS = 4;
  // Stored entry is {inst, isCsr, exception, cause}
  localparam int ENTRY_BITS = INST_BITS + 2 + CAUSE_BITS;

  // Low opcode field of the instruction word
  localparam int OPCODE_BITS = 7;
  localparam logic [OPCODE_BITS-1:0] OP_LOAD_FP = 7'b0000111;
  localparam logic [OPCODE_BITS-1:0] OP_STORE_FP = 7'b0100111;
  localparam logic [OPCODE_BITS-1:0] OP_OP_FP = 7'b1010011;

  // Status word and its FP-enable flag
  localparam int STATUS_BITS = 32;
  localparam int STATUS_FP_EN_BIT = 4;

  // Cause reported when an FP opcode arrives with the FPU disabled
  localparam logic [CAUSE_BITS-1:0] CAUSE_FP_DISABLED = 4'h7;

endpackage

`default_nettype wire

// ==== verilog/ibufQueueCtrl.sv ====
/* Instruction buffer queue control
   Head, tail and count registers, packed write addressing, full flag, read addresses */
`timescale 1ns/100ps
`default_nettype none

module ibufQueueCtrl
  import ibufPkg::*;
(
  input  wire logic                                     clk,
  input  wire logic                                     reset,
  input  wire logic                                     flush_i,

  // Decode side
  input  wire logic                                     decodeReady_i,
  input  wire logic [WR_LANES-1:0]                      inValid_i,
  output logic                                          full_o,

  // Lanes taken by dispatch this cycle
  input  wire logic [RD_CNT_BITS-1:0]                   popCount_i,

  // Storage addressing
  output logic      [WR_LANES-1:0]                      wrEn_o,
  output logic      [WR_LANES-1:0][IBUF_PTR_BITS-1:0]   wrAddr_o,
  output logic      [RD_LANES-1:0][IBUF_PTR_BITS-1:0]   rdAddr_o,

  // Occupancy for dispatch control
  output logic      [IBUF_CNT_BITS-1:0]                 entryCount_o
);

  // Queue state
  logic [IBUF_PTR_BITS-1:0] headQ;
  logic [IBUF_PTR_BITS-1:0] tailQ;
  logic [IBUF_CNT_BITS-1:0] countQ;

  // Next-state values
  logic [IBUF_PTR_BITS-1:0] headNext;
  logic [IBUF_PTR_BITS-1:0] tailNext;
  logic [IBUF_CNT_BITS-1:0] countNext;

  // Write bookkeeping
  logic                     accept;
  logic [IBUF_CNT_BITS-1:0] wrCount;

  // Wrap a widened pointer sum back into the queue by compare and subtract
  function automatic logic [IBUF_PTR_BITS-1:0] wrapPtr(
    input logic [IBUF_CNT_BITS-1:0] sum
  );
    logic [IBUF_CNT_BITS-1:0] wrapped;
    wrapped = sum;
    if (sum >= IBUF_CNT_BITS'(IBUF_DEPTH))
    begin
      wrapped = sum - IBUF_CNT_BITS'(IBUF_DEPTH);
    end
    return wrapped[IBUF_PTR_BITS-1:0];
  endfunction

  // Room must remain for a fully loaded write
  assign full_o = countQ > IBUF_CNT_BITS'(IBUF_DEPTH - WR_LANES);

  // All lanes or none
  assign accept = decodeReady_i & ~full_o;

  assign entryCount_o = countQ;

  // Valid lanes are packed onto consecutive entries from the tail
  always_comb
  begin : writeAddr
    logic [IBUF_CNT_BITS-1:0] offset;
    offset = IBUF_CNT_BITS'(tailQ);
    wrCount = '0;
    for (int w = 0; w < WR_LANES; w++)
    begin
      wrEn_o[w] = accept & inValid_i[w];
      wrAddr_o[w] = wrapPtr(offset);
      // Gaps between valid lanes do not consume an entry
      offset = offset + IBUF_CNT_BITS'(inValid_i[w]);
      wrCount = wrCount + IBUF_CNT_BITS'(wrEn_o[w]);
    end
  end

  // Dispatch bundle reads head, head+1
  always_comb
  begin
    for (int r = 0; r < RD_LANES; r++)
    begin
      rdAddr_o[r] = wrapPtr(IBUF_CNT_BITS'(headQ) + IBUF_CNT_BITS'(r));
    end
  end

  // Tail moves by the lanes written, head by the lanes dispatched
  assign tailNext = wrapPtr(IBUF_CNT_BITS'(tailQ) + wrCount);
  assign headNext = wrapPtr(IBUF_CNT_BITS'(headQ) + IBUF_CNT_BITS'(popCount_i));

  // Count takes both adjustments in the same cycle
  assign countNext = countQ + wrCount - IBUF_CNT_BITS'(popCount_i);

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      headQ <= '0;
      tailQ <= '0;
      countQ <= '0;
    end
    else if (flush_i)
    begin
      // Flush drops every waiting packet
      headQ <= '0;
      tailQ <= '0;
      countQ <= '0;
    end
    else
    begin
      headQ <= headNext;
      tailQ <= tailNext;
      countQ <= countNext;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/ibufRam.sv ====
/* Instruction buffer storage
   Multi-port entry array, one write port per decode lane, combinational reads */
`timescale 1ns/100ps
`default_nettype none

module ibufRam
  import ibufPkg::*;
(
  input  wire logic                                     clk,

  // Write ports, one per decode lane
  input  wire logic [WR_LANES-1:0]                      wrEn_i,
  input  wire logic [WR_LANES-1:0][IBUF_PTR_BITS-1:0]   wrAddr_i,
  input  wire logic [WR_LANES-1:0][ENTRY_BITS-1:0]      wrData_i,

  // Read ports for the dispatch bundle
  input  wire logic [RD_LANES-1:0][IBUF_PTR_BITS-1:0]   rdAddr_i,
  output logic      [RD_LANES-1:0][ENTRY_BITS-1:0]      rdData_o
);

  // Entry array
  logic [ENTRY_BITS-1:0] mem [IBUF_DEPTH];

  // Packed writes land on distinct entries, so lane order does not matter
  always_ff @(posedge clk)
  begin
    for (int w = 0; w < WR_LANES; w++)
    begin
      if (wrEn_i[w])
      begin
        mem[wrAddr_i[w]] <= wrData_i[w];
      end
    end
  end

  // Head and head+1 are read without a clock
  always_comb
  begin
    for (int r = 0; r < RD_LANES; r++)
    begin
      rdData_o[r] = mem[rdAddr_i[r]];
    end
  end

endmodule

`default_nettype wire

// ==== verilog/instructionBuffer.sv ====
/* Instruction buffer top
   Circular queue between decode and dispatch, 4 lanes in and a 2-wide bundle out */
`timescale 1ns/100ps
`default_nettype none

module instructionBuffer
  import ibufPkg::*;
(
  input  wire logic                                     clk,
  input  wire logic                                     reset,
  input  wire logic                                     flush_i,
  input  wire logic                                     stall_i,
  input  wire logic                                     commitCsr_i,
  input  wire logic [STATUS_BITS-1:0]                   statusWord_i,

  // Decode write lanes
  input  wire logic                                     decodeReady_i,
  input  wire logic [WR_LANES-1:0]                      inValid_i,
  input  wire logic [WR_LANES-1:0][INST_BITS-1:0]       inInst_i,
  input  wire logic [WR_LANES-1:0]                      inIsCsr_i,
  input  wire logic [WR_LANES-1:0]                      inException_i,
  input  wire logic [WR_LANES-1:0][CAUSE_BITS-1:0]      inCause_i,
  output logic                                          full_o,

  // Dispatch bundle
  output logic                                          ready_o,
  output logic                                          serializeStall_o,
  output logic      [RD_LANES-1:0]                      outValid_o,
  output logic      [RD_LANES-1:0][INST_BITS-1:0]       outInst_o,
  output logic      [RD_LANES-1:0]                      outIsCsr_o,
  output logic      [RD_LANES-1:0]                      outException_o,
  output logic      [RD_LANES-1:0][CAUSE_BITS-1:0]      outCause_o
);

  // Storage side
  logic [WR_LANES-1:0]                      wrEn;
  logic [WR_LANES-1:0][IBUF_PTR_BITS-1:0]   wrAddr;
  logic [WR_LANES-1:0][ENTRY_BITS-1:0]      wrData;
  logic [RD_LANES-1:0][IBUF_PTR_BITS-1:0]   rdAddr;
  logic [RD_LANES-1:0][ENTRY_BITS-1:0]      rdData;

  // Entry fields at head
  logic [RD_LANES-1:0][INST_BITS-1:0]       rdInst;
  logic [RD_LANES-1:0]                      rdIsCsr;
  logic [RD_LANES-1:0]                      rdException;
  logic [RD_LANES-1:0][CAUSE_BITS-1:0]      rdCause;

  // Queue and dispatch handshake
  logic [IBUF_CNT_BITS-1:0]                 entryCount;
  logic [RD_CNT_BITS-1:0]                   popCount;

  // Entry layout {inst, isCsr, exception, cause}
  for (genvar w = 0; w < WR_LANES; w++)
  begin : gWrPack
    assign wrData[w] = {inInst_i[w], inIsCsr_i[w], inException_i[w], inCause_i[w]};
  end

  for (genvar r = 0; r < RD_LANES; r++)
  begin : gRdSplit
    assign {rdInst[r], rdIsCsr[r], rdException[r], rdCause[r]} = rdData[r];
  end

  ibufRam ram (
    .clk      (clk),
    .wrEn_i   (wrEn),
    .wrAddr_i (wrAddr),
    .wrData_i (wrData),
    .rdAddr_i (rdAddr),
    .rdData_o (rdData)
  );

  ibufQueueCtrl queueCtrl (
    .clk           (clk),
    .reset         (reset),
    .flush_i       (flush_i),
    .decodeReady_i (decodeReady_i),
    .inValid_i     (inValid_i),
    .full_o        (full_o),
    .popCount_i    (popCount),
    .wrEn_o        (wrEn),
    .wrAddr_o      (wrAddr),
    .rdAddr_o      (rdAddr),
    .entryCount_o  (entryCount)
  );

  // Every stored entry came from a valid decode lane
  ibufDispatchCtrl dispatchCtrl (
    .clk              (clk),
    .reset            (reset),
    .flush_i          (flush_i),
    .stall_i          (stall_i),
    .commitCsr_i      (commitCsr_i),
    .statusWord_i     (statusWord_i),
    .entryCount_i     (entryCount),
    .rdInst_i         (rdInst),
    .rdValid_i        ({RD_LANES{1'b1}}),
    .rdIsCsr_i        (rdIsCsr),
    .rdException_i    (rdException),
    .rdCause_i        (rdCause),
    .ready_o          (ready_o),
    .serializeStall_o (serializeStall_o),
    .outValid_o       (outValid_o),
    .outIsCsr_o       (outIsCsr_o),
    .outException_o   (outException_o),
    .outInst_o        (outInst_o),
    .outCause_o       (outCause_o),
    .popCount_o       (popCount)
  );

endmodule

`default_nettype wire

// ==== vlog.f ====
verilog/ibufPkg.sv
verilog/ibufRam.sv
verilog/ibufQueueCtrl.sv
verilog/ibufDispatchCtrl.sv
verilog/instructionBuffer.sv
tests/instructionBuffer_checker.sv
tests/instructionBufferTb.sv
